/* hw/blit_pkg.sv */
`default_nettype none

package blit_pkg;

  // Frame geometry
  localparam int SCREEN_W = 640;
  localparam int SCREEN_H = 480;
  localparam int FB_AW    = 19;           // Frame address is y*SCREEN_W + x
  localparam int X_W      = 10;           // Bits of an x coordinate or sprite width
  localparam int Y_W      = 9;            // Bits of a y coordinate or sprite height

  typedef logic [5:0] pixel_t;

  localparam pixel_t BACKGROUND  = 6'h3F; // Clear colour
  localparam pixel_t TRANSPARENT = 6'h24; // Skipped on add

  ////////////////////////////////
  // Sprite ROM layout
  ////////////////////////////////
  localparam int NUM_SPRITES = 4;
  localparam int SPRITE_SLOT = 64;        // Words per sprite, sprite n at n*SPRITE_SLOT
  localparam int ROM_AW      = 8;
  localparam int HDR_WORDS   = 4;         // Width hi, width lo, height hi, height lo
  localparam int HDR_SHIFT   = 6;         // Size is hi*64 + lo
  localparam string ROM_FILE = "hw/sprites.hex";

endpackage

`default_nettype wire

/* hw/axil_pkg.sv */
`default_nettype none

package axil_pkg;

  localparam int AXI_AW = 4;
  localparam int AXI_DW = 32;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register map
  localparam logic [AXI_AW-1:0] REG_CMD    = 4'h0;
  localparam logic [AXI_AW-1:0] REG_STATUS = 4'h4; // Busy in bit 0

  ////////////////////////////////
  // Command word fields
  ////////////////////////////////
  localparam int CMD_OP_MSB  = 1;
  localparam int CMD_OP_LSB  = 0;
  localparam int CMD_IDX_MSB = 7;
  localparam int CMD_IDX_LSB = 2;
  localparam int CMD_X_MSB   = 17;
  localparam int CMD_X_LSB   = 8;
  localparam int CMD_Y_MSB   = 26;
  localparam int CMD_Y_LSB   = 18;

  localparam logic [1:0] OP_ADD    = 2'd1;
  localparam logic [1:0] OP_REMOVE = 2'd2; // Any other op is refused

endpackage

`default_nettype wire

/* hw/blit_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One decoded command from the register block to the placer
interface blit_cmd_if import blit_pkg::*, axil_pkg::*; ();

  logic                            start;  // Single cycle, command accepted
  logic                            remove; // Clear rectangle instead of drawing
  logic [CMD_IDX_MSB-CMD_IDX_LSB:0] index;
  logic [X_W-1:0]                  x;      // Upper left corner
  logic [Y_W-1:0]                  y;
  logic                            busy;   // Placer not idle

  modport ctrl (output start, remove, index, x, y, input busy);

  modport engine (input start, remove, index, x, y, output busy);

endinterface

`default_nettype wire

/* hw/axil_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_cmd_regs
  import blit_pkg::*, axil_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  // Write address and data, taken together
  input  logic [AXI_AW-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [AXI_DW-1:0]   wdata,
  input  logic [AXI_DW/8-1:0] wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  // Read channel
  input  logic [AXI_AW-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [AXI_DW-1:0]   rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  blit_cmd_if.ctrl            cmd
);

  logic              wr_hs;   // AW and W handshake in the same cycle
  logic              rd_hs;
  logic [AXI_DW-1:0] wword;   // Write data merged with stored word under wstrb
  logic [AXI_DW-1:0] cmd_q;   // Last accepted command, read back at REG_CMD
  logic [1:0]        op;
  logic              cmd_ok;

  ///////////////////////////////
  // Write side
  ///////////////////////////////
  assign wr_hs   = awvalid && wvalid && !bvalid; // Pending response blocks new writes
  assign awready = wr_hs;
  assign wready  = wr_hs;

  always_comb begin
    for (int b = 0; b < AXI_DW / 8; b++) begin
      wword[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : cmd_q[8*b +: 8]; // Unstrobed bytes keep
    end
  end

  assign op = wword[CMD_OP_MSB:CMD_OP_LSB];

  // Legal only to REG_CMD, while idle, with a known op and sprite
  assign cmd_ok = wr_hs && (awaddr == REG_CMD) && !cmd.busy &&
                  (op == OP_ADD || op == OP_REMOVE) &&
                  (int'(wword[CMD_IDX_MSB:CMD_IDX_LSB]) < NUM_SPRITES);

  // Decoded fields go straight out, start qualifies them
  assign cmd.start  = cmd_ok;
  assign cmd.remove = (op == OP_REMOVE);
  assign cmd.index  = wword[CMD_IDX_MSB:CMD_IDX_LSB];
  assign cmd.x      = wword[CMD_X_MSB:CMD_X_LSB];
  assign cmd.y      = wword[CMD_Y_MSB:CMD_Y_LSB];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_hs) begin
      bvalid <= 1'b1;             // Response the cycle after the handshake
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= cmd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q <= '0;
    end else if (cmd_ok) begin
      cmd_q <= wword;
    end
  end

  ///////////////////////////////
  // Read side
  ///////////////////////////////
  assign arready = !rvalid;
  assign rd_hs   = arvalid && !rvalid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= '0;                // Unmapped offsets read zero
      rresp <= RESP_OKAY;
      case (araddr)
        REG_CMD:    rdata <= cmd_q;
        REG_STATUS: rdata[0] <= cmd.busy;
        default:    rresp <= RESP_SLVERR;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/bitmap_placer.sv */
`timescale 1ns/1ps
`default_nettype none

module bitmap_placer
  import blit_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  blit_cmd_if.engine        cmd,
  output logic [ROM_AW-1:0] rom_addr,
  input  pixel_t            rom_data,   // One cycle after rom_addr
  output logic              fb_we,
  output logic [FB_AW-1:0]  fb_waddr,
  output pixel_t            fb_wdata
);

  enum logic [2:0] {CLEAR, IDLE, ADV, WID_HI, WID_LO, HGT_HI, HGT_LO, WRT} state, nxt;

  logic [ROM_AW:0]   rom_ptr;  // One extra bit so the end of the last slot fits
  logic [ROM_AW:0]   rom_end;  // First pointer value past the sprite, plus read latency
  logic [FB_AW-1:0]  wptr;     // Frame address of the pixel in flight
  logic [FB_AW-1:0]  wrap;     // Last address of the current row
  logic [X_W-1:0]    wid;
  logic [Y_W-1:0]    hgt_hi;
  logic [Y_W-1:0]    hgt;      // Full height, valid in HGT_LO
  logic [FB_AW-1:0]  area;     // Pixels in the sprite
  logic              rem;
  logic              rom_inc;
  logic              pix_go;   // Pixel on rom_data belongs to the sprite
  logic              row_end;
  logic              we_c;
  pixel_t            wdata_c;

  assign rom_addr = rom_ptr[ROM_AW-1:0];
  assign hgt      = hgt_hi + Y_W'(rom_data);
  assign area     = FB_AW'(wid) * FB_AW'(hgt);
  assign pix_go   = (state == WRT) && (rom_ptr < rom_end);
  assign row_end  = (wptr == wrap);
  assign cmd.busy = (state != IDLE);

  ///////////////////////////////
  // Sequencing
  ///////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CLEAR;              // Paint whole frame first
    end else begin
      state <= nxt;
    end
  end

  always_comb begin
    nxt     = state;
    rom_inc = 1'b0;
    we_c    = 1'b0;
    wdata_c = BACKGROUND;
    case (state)
      CLEAR: begin
        we_c = 1'b1;               // One pixel per cycle
        if (wptr == FB_AW'(SCREEN_W * SCREEN_H - 1)) begin
          nxt = IDLE;
        end
      end
      IDLE: begin
        if (cmd.start) begin
          nxt = ADV;
        end
      end
      ADV: begin
        rom_inc = 1'b1;            // Header word 0 on its way
        nxt     = WID_HI;
      end
      WID_HI: begin
        rom_inc = 1'b1;
        nxt     = WID_LO;
      end
      WID_LO: begin
        rom_inc = 1'b1;
        nxt     = HGT_HI;
      end
      HGT_HI: begin
        rom_inc = 1'b1;
        nxt     = HGT_LO;
      end
      HGT_LO: begin
        rom_inc = 1'b1;            // First pixel arrives in WRT
        nxt     = WRT;
      end
      WRT: begin
        if (pix_go) begin
          rom_inc = 1'b1;
          wdata_c = rem ? BACKGROUND : rom_data;
          we_c    = rem || (rom_data != TRANSPARENT);
        end else begin
          nxt = IDLE;              // Spare cycle sees the end
        end
      end
      default: nxt = IDLE;
    endcase
  end

  ///////////////////////////////
  // Address counters
  ///////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rom_ptr <= '0;
    end else if (state == IDLE && cmd.start) begin
      rom_ptr <= (ROM_AW+1)'(cmd.index * SPRITE_SLOT); // Slot base of the sprite
    end else if (rom_inc) begin
      rom_ptr <= rom_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
    end else if (state == CLEAR) begin
      wptr <= wptr + 1'b1;
    end else if (state == IDLE && cmd.start) begin
      wptr <= FB_AW'(cmd.y * SCREEN_W + cmd.x);
    end else if (pix_go) begin
      if (row_end) begin
        // Next row start is SCREEN_W - wid past the pixel after this one
        wptr <= wptr + FB_AW'(SCREEN_W + 1) - FB_AW'(wid);
      end else begin
        wptr <= wptr + 1'b1;
      end
    end
  end

  // Header capture and derived limits
  always_ff @(posedge clk) begin
    if (state == IDLE && cmd.start) begin
      rem <= cmd.remove;
    end
    if (state == WID_HI) begin
      wid <= X_W'(rom_data) << HDR_SHIFT;
    end
    if (state == WID_LO) begin
      wid <= wid + X_W'(rom_data);
    end
    if (state == HGT_HI) begin
      hgt_hi <= Y_W'(rom_data) << HDR_SHIFT;
      wrap   <= wptr + FB_AW'(wid) - 1'b1;          // Width known by now
    end else if (pix_go && row_end) begin
      wrap <= wrap + FB_AW'(SCREEN_W);
    end
    if (state == HGT_LO) begin
      rom_end <= rom_ptr + 1'b1 + (ROM_AW+1)'(area); // rom_ptr sits past the header
    end
  end

  ///////////////////////////////
  // Write port register
  ///////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fb_we <= 1'b0;
    end else begin
      fb_we <= we_c;
    end
  end

  always_ff @(posedge clk) begin
    fb_waddr <= wptr;
    fb_wdata <= wdata_c;
  end

endmodule

`default_nettype wire

/* hw/sprite_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_rom
  import blit_pkg::*;
(
  input  logic              clk,
  input  logic [ROM_AW-1:0] addr,
  output pixel_t            data
);

  // Four slots of header plus pixels
  pixel_t mem [NUM_SPRITES * SPRITE_SLOT];

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  always_ff @(posedge clk) begin
    data <= mem[addr];  // Registered read
  end

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
  import blit_pkg::*;
(
  input  logic             clk,
  input  logic             we,
  input  logic [FB_AW-1:0] waddr,
  input  pixel_t           wdata,
  input  logic [FB_AW-1:0] rd_addr,
  output pixel_t           rd_data
);

  pixel_t mem [SCREEN_W * SCREEN_H]; // Row-major frame

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];         // External port, one cycle latency
  end

endmodule

`default_nettype wire

/* hw/blit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module blit_top
  import blit_pkg::*, axil_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [AXI_AW-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [AXI_DW-1:0]   wdata,
  input  logic [AXI_DW/8-1:0] wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [AXI_AW-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [AXI_DW-1:0]   rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  input  logic [FB_AW-1:0]    rd_addr,  // Pixel inspection port
  output pixel_t              rd_data
);

  logic [ROM_AW-1:0] rom_addr;
  pixel_t            rom_data;
  logic              fb_we;
  logic [FB_AW-1:0]  fb_waddr;
  pixel_t            fb_wdata;

  blit_cmd_if cmd_if ();

  axil_cmd_regs regs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cmd     (cmd_if.ctrl)
  );

  bitmap_placer placer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd_if.engine),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_wdata (fb_wdata)
  );

  sprite_rom rom_i (
    .clk  (clk),
    .addr (rom_addr),
    .data (rom_data)
  );

  frame_buffer fb_i (
    .clk     (clk),
    .we      (fb_we),
    .waddr   (fb_waddr),
    .wdata   (fb_wdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;        // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(negedge clk);    // Ten cycles, released on a falling edge
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/blit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module blit_tb import blit_pkg::*, axil_pkg::*; ();

  localparam int FB_PIXELS   = SCREEN_W * SCREEN_H;
  localparam int CLEAR_POLLS = 150000;  // About three cycles per status poll
  localparam int CMD_POLLS   = 500;
  localparam int HS_CYCLES   = 50;      // Limit for any AXI handshake

  logic                clk;
  logic                rst_n;
  logic [AXI_AW-1:0]   awaddr;
  logic                awvalid;
  logic                awready;
  logic [AXI_DW-1:0]   wdata;
  logic [AXI_DW/8-1:0] wstrb;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  logic [AXI_AW-1:0]   araddr;
  logic                arvalid;
  logic                arready;
  logic [AXI_DW-1:0]   rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;
  logic [FB_AW-1:0]    rd_addr;
  pixel_t              rd_data;

  logic   aw_taken;                              // AW handshake at the last rising edge
  logic   w_taken;
  logic   ar_taken;

  pixel_t rom_model [NUM_SPRITES * SPRITE_SLOT]; // Same image as the sprite ROM
  pixel_t frame_model [FB_PIXELS];               // Expected frame contents
  integer seed;
  int     err_cnt;
  int     timeout_cnt;
  int     spr_x [NUM_SPRITES];                   // Random placements from the add test
  int     spr_y [NUM_SPRITES];

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  blit_top blit_top_i (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  // Handshakes as the DUT saw them at the rising edge
  always @(posedge clk) begin
    aw_taken <= awvalid && awready;
    w_taken  <= wvalid && wready;
    ar_taken <= arvalid && arready;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_pixel(input string tname, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", tname, exp, act);
    end
  endtask

  task automatic check_resp(input string tname, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", tname, exp, act);
    end
  endtask

  task automatic check_word(input string tname, input logic [AXI_DW-1:0] exp,
                            input logic [AXI_DW-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", tname, exp, act);
    end
  endtask

  //////////////////////////////
  // Sprite model, header rule
  //////////////////////////////
  function automatic int sprite_w(input int idx);
    return int'(rom_model[idx*SPRITE_SLOT]) * 64 + int'(rom_model[idx*SPRITE_SLOT + 1]);
  endfunction

  function automatic int sprite_h(input int idx);
    return int'(rom_model[idx*SPRITE_SLOT + 2]) * 64 + int'(rom_model[idx*SPRITE_SLOT + 3]);
  endfunction

  function automatic int rand_range(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;   // 0 to n-1
  endfunction

  function automatic logic [AXI_DW-1:0] cmd_word(input logic [1:0] op, input int idx,
                                                 input int x, input int y);
    logic [AXI_DW-1:0] w;
    w = '0;
    w[CMD_OP_MSB:CMD_OP_LSB]   = op;
    w[CMD_IDX_MSB:CMD_IDX_LSB] = idx[CMD_IDX_MSB-CMD_IDX_LSB:0];
    w[CMD_X_MSB:CMD_X_LSB]     = x[CMD_X_MSB-CMD_X_LSB:0];
    w[CMD_Y_MSB:CMD_Y_LSB]     = y[CMD_Y_MSB-CMD_Y_LSB:0];
    return w;
  endfunction

  // Add skips transparent pixels, remove paints background over the rectangle
  task automatic model_update(input logic remove, input int idx, input int x, input int y);
    int w;
    int h;
    int a;
    pixel_t p;
    w = sprite_w(idx);
    h = sprite_h(idx);
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        p = rom_model[idx*SPRITE_SLOT + HDR_WORDS + r*w + c]; // Row-major pixels
        a = (y + r) * SCREEN_W + x + c;
        if (remove) begin
          frame_model[a] = BACKGROUND;
        end else if (p != TRANSPARENT) begin
          frame_model[a] = p;
        end
      end
    end
  endtask

  //////////////////////////////
  // Bus and pixel access
  //////////////////////////////
  task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                           input int hold, output logic [1:0] resp);
    int n;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);           // Held low for hold cycles of back-pressure
    n = 0;
    @(negedge clk);
    while (!aw_taken && !w_taken && n < HS_CYCLES) begin
      @(negedge clk);
      n++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!aw_taken && !w_taken) begin
      timeout_cnt++;
      $display("Write to offset %h was never accepted", addr);
    end else if (aw_taken !== w_taken) begin
      err_cnt++;
      $display("Write address and data to offset %h were not accepted together", addr);
    end else if (!bvalid) begin
      err_cnt++;
      $display("No write response to offset %h the cycle after the handshake", addr);
    end
    resp = bresp;
    for (n = 0; n < hold; n++) begin
      @(negedge clk);
      if (!bvalid) begin
        err_cnt++;
        $display("Write response to offset %h dropped while bready was low", addr);
      end
    end
    bready = 1'b1;
    n = 0;
    @(negedge clk);
    while (bvalid && n < HS_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (bvalid) begin
      timeout_cnt++;
      $display("Write response to offset %h never completed", addr);
    end
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_AW-1:0] addr, input int hold,
                          output logic [AXI_DW-1:0] data, output logic [1:0] resp);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    n = 0;
    @(negedge clk);
    while (!ar_taken && n < HS_CYCLES) begin
      @(negedge clk);
      n++;
    end
    arvalid = 1'b0;
    if (!ar_taken) begin
      timeout_cnt++;
      $display("Read of offset %h was never accepted", addr);
    end else if (!rvalid) begin
      err_cnt++;
      $display("No read data from offset %h the cycle after the handshake", addr);
    end
    data = rdata;
    resp = rresp;
    for (n = 0; n < hold; n++) begin
      @(negedge clk);
      if (!rvalid || rdata !== data) begin
        err_cnt++;
        $display("Read data of offset %h not held while rready was low", addr);
      end
    end
    rready = 1'b1;
    n = 0;
    @(negedge clk);
    while (rvalid && n < HS_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (rvalid) begin
      timeout_cnt++;
      $display("Read of offset %h never completed", addr);
    end
    rready = 1'b0;
  endtask

  // Poll REG_STATUS until busy falls
  task automatic wait_idle(input string tname, input int limit);
    logic [AXI_DW-1:0] d;
    logic [1:0]        r;
    int                n;
    n = 0;
    axi_read(REG_STATUS, 0, d, r);
    while (d[0] !== 1'b0 && n < limit) begin
      axi_read(REG_STATUS, 0, d, r);
      n++;
    end
    if (d[0] !== 1'b0) begin
      timeout_cnt++;
      $display("%s: blitter still busy after %0d status polls", tname, limit);
    end
  endtask

  task automatic read_pixel(input int x, input int y, output pixel_t p);
    @(negedge clk);
    rd_addr = FB_AW'(y * SCREEN_W + x);
    @(negedge clk);                  // One cycle read latency
    p = rd_data;
  endtask

  // Rectangle plus a one pixel ring, clipped to the frame
  task automatic check_region(input string tname, input int x, input int y,
                              input int w, input int h);
    pixel_t p;
    for (int r = y - 1; r <= y + h; r++) begin
      for (int c = x - 1; c <= x + w; c++) begin
        if (r >= 0 && r < SCREEN_H && c >= 0 && c < SCREEN_W) begin
          read_pixel(c, r, p);
          check_pixel(tname, frame_model[r*SCREEN_W + c], p);
        end
      end
    end
  endtask

  task automatic place(input string tname, input logic [1:0] op, input int idx,
                       input int x, input int y);
    logic [1:0] resp;
    axi_write(REG_CMD, cmd_word(op, idx, x, y), 0, resp);
    check_resp(tname, RESP_OKAY, resp);
    model_update(op == OP_REMOVE, idx, x, y);
    wait_idle(tname, CMD_POLLS);
    check_region(tname, x, y, sprite_w(idx), sprite_h(idx));
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_reset_clear();
    pixel_t p;
    int     x;
    int     y;
    wait_idle("reset_clear", CLEAR_POLLS);
    for (int i = 0; i < 204; i++) begin
      if (i < 4) begin
        x = (i % 2 == 1) ? SCREEN_W - 1 : 0;  // Four corners first
        y = (i >= 2) ? SCREEN_H - 1 : 0;
      end else begin
        x = rand_range(SCREEN_W);
        y = rand_range(SCREEN_H);
      end
      read_pixel(x, y, p);
      check_pixel("reset_clear", BACKGROUND, p);
    end
  endtask

  task automatic test_add_sprites();
    for (int idx = 0; idx < NUM_SPRITES; idx++) begin
      spr_x[idx] = rand_range(SCREEN_W - sprite_w(idx) + 1);
      spr_y[idx] = rand_range(SCREEN_H - sprite_h(idx) + 1);
      place("add_sprite", OP_ADD, idx, spr_x[idx], spr_y[idx]);
    end
    // Sprite 0 over sprite 3, its transparent pixels must show sprite 3
    place("add_transparent", OP_ADD, 0, spr_x[3], spr_y[3]);
  endtask

  task automatic test_remove();
    place("remove_setup", OP_ADD, 1, 100, 200);
    place("remove_setup", OP_ADD, 2, 100 + sprite_w(1), 200); // Right neighbour
    place("remove_sprite", OP_REMOVE, 1, 100, 200);
    check_region("remove_neighbour", 100 + sprite_w(1), 200, sprite_w(2), sprite_h(2));
  endtask

  task automatic test_illegal();
    logic [1:0]        resp;
    logic [AXI_DW-1:0] d;
    logic [1:0]        r;
    logic [1:0]        ops  [4];
    int                idxs [4];
    ops  = '{2'd0, 2'd3, OP_ADD, OP_REMOVE};
    idxs = '{0, 1, NUM_SPRITES, 63};
    for (int i = 0; i < 4; i++) begin
      axi_write(REG_CMD, cmd_word(ops[i], idxs[i], 400, 100), 0, resp);
      check_resp("illegal_cmd", RESP_SLVERR, resp);
      axi_read(REG_STATUS, 0, d, r);
      check_word("illegal_not_busy", 32'h0, d);  // Nothing started
    end
    check_region("illegal_no_write", 400, 100, 8, 8);
    // Second command lands while the first is running
    axi_write(REG_CMD, cmd_word(OP_ADD, 3, 500, 300), 0, resp);
    check_resp("busy_first", RESP_OKAY, resp);
    model_update(1'b0, 3, 500, 300);
    axi_write(REG_CMD, cmd_word(OP_ADD, 1, 20, 400), 0, resp);
    check_resp("busy_refused", RESP_SLVERR, resp);
    wait_idle("busy_refused", CMD_POLLS);
    check_region("busy_first", 500, 300, sprite_w(3), sprite_h(3));
    check_region("busy_refused", 20, 400, sprite_w(1), sprite_h(1));
  endtask

  task automatic test_registers();
    logic [AXI_DW-1:0] word;
    logic [AXI_DW-1:0] d;
    logic [1:0]        resp;
    word = cmd_word(OP_ADD, 3, 250, 50);
    axi_write(REG_CMD, word, 3, resp);           // Delayed bready
    check_resp("delayed_bready", RESP_OKAY, resp);
    model_update(1'b0, 3, 250, 50);
    axi_read(REG_STATUS, 0, d, resp);
    check_word("status_busy", 32'h1, d);
    check_resp("status_busy", RESP_OKAY, resp);
    wait_idle("status_busy", CMD_POLLS);
    check_region("delayed_bready", 250, 50, sprite_w(3), sprite_h(3));
    axi_read(REG_CMD, 4, d, resp);               // Delayed rready
    check_word("cmd_readback", word, d);
    check_resp("cmd_readback", RESP_OKAY, resp);
    axi_write(REG_STATUS, 32'h1, 0, resp);
    check_resp("status_write", RESP_SLVERR, resp);
    axi_write(REG_CMD, cmd_word(2'd3, 0, 10, 10), 0, resp);
    check_resp("readback_kept", RESP_SLVERR, resp);
    axi_read(REG_CMD, 0, d, resp);
    check_word("readback_kept", word, d);        // Refused word not stored
    axi_read(4'h8, 0, d, resp);
    check_word("unmapped_read", 32'h0, d);
    check_resp("unmapped_read", RESP_SLVERR, resp);
    axi_read(REG_STATUS, 0, d, resp);
    check_word("status_idle", 32'h0, d);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int n;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    rd_addr     = '0;
    seed        = 29810;
    err_cnt     = 0;
    timeout_cnt = 0;
    $readmemh("hw/sprites.hex", rom_model);
    for (int i = 0; i < FB_PIXELS; i++) begin
      frame_model[i] = BACKGROUND;   // Placer clears the frame after reset
    end
    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      timeout_cnt++;
      $display("Reset was never released");
    end
    test_reset_clear();
    test_add_sprites();
    test_remove();
    test_illegal();
    test_registers();
    $display("Summary: %0d check errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/sprites.hex */
// Four 64-word sprite slots at 00, 40, 80, c0. First line of a slot is the header:
// width hi, width lo, height hi, height lo (size = hi*64 + lo), then one line per pixel row
@00
00 05 00 04
24 11 11 11 24
11 2a 2a 2a 11
11 2a 24 2a 11
24 11 11 11 24
@40
00 08 00 06
24 24 05 05 05 05 24 24
24 05 0c 0c 0c 0c 05 24
05 0c 30 0c 0c 30 0c 05
05 0c 0c 0c 0c 0c 0c 05
24 05 0c 19 19 0c 05 24
24 24 05 05 05 05 24 24
@80
00 03 00 03
38 24 38
24 3e 24
38 24 38
@c0
00 07 00 08
01 02 03 04 05 06 24
07 08 09 0a 0b 0c 24
0d 0e 0f 10 12 13 24
14 15 16 17 18 1a 1b
1c 1d 1e 1f 20 21 22
23 24 25 26 27 28 29
2b 2c 2d 2e 2f 31 32
33 34 35 36 37 39 3a

/* sources.f */
hw/blit_pkg.sv
hw/axil_pkg.sv
hw/blit_cmd_if.sv
hw/axil_cmd_regs.sv
hw/bitmap_placer.sv
hw/sprite_rom.sv
hw/frame_buffer.sv
hw/blit_top.sv
verif/tb_clk_gen.sv
verif/blit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the blitter testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module blit_tb -f sources.f
out=$(./obj_dir/Vblit_tb)
echo "$out"
if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1
